//--- rtl/coeff_rom.mem
// One 64-bit word per line: exponent [63:62], c2 [61:50], c1 [49:30], c0 [29:0]
// Lines 0 to 15 are reciprocal by index, lines 16 to 31 square root by index
0A3F1C2B5E7D9104
4B2E0D9F3C6A8215
8C1D2E3F4A5B6C7D
C3E2D1F0A9B8C7D6
1F0E2D3C4B5A6978
5E4D3C2B1A098F7E
9D8C7B6A5F4E3D2C
D1C2B3A4958677E8
27A9B3C5D7E9F102
63B5C7D9E1F20314
A4C6E8F0123456AB
E5D7C9BA9C8E7F60
3A5C7E9B1D2F4061
7B6D5F4E3D2C1B0A
B2D4F6A8C0E1357A
F1E3D5C7B9A08264
0C9E8D7F6A5B4C3D
4D8F7E6A5C4B3A29
8E7D6C5B4A3F2E1D
CF6E5D4C3B2A1908
2A4B6C8DAEBFC0D1
6B5C4D3E2F1A0B9C
AC3D5E7F9011A2B3
ED2C4B6A8F9E0D1C
13579BDF02468ACE
579BDF13579BDF13
9ACE02468ACE0246
DB97531FECA86420
3C6F9A2D5E8B1047
7D0A3E6B9C2F5184
BE1F4A7D2C5B8E03
FA2B5C8D1E4F7096

//--- sim.f
rtl/seed_params_pkg.sv
rtl/seed_types_pkg.sv
rtl/seed_pipe_if.sv
rtl/coeff_table.sv
rtl/square_unit.sv
rtl/booth_recoder.sv
rtl/operand_stage.sv
rtl/pp_reduce.sv
rtl/seed_eval_top.sv
dv/seed_eval_assertions.sv
dv/tb_seed_eval.sv

//--- dv/tb_seed_eval.sv
`timescale 1ns/10ps

module tb_seed_eval
    import seed_params_pkg::*;
    import seed_types_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = 3000;
    localparam int RANDOM_COUNT = 800;

    logic                    clk;
    logic                    rst;
    logic                    enable;
    logic                    is_sqrt;
    logic [OP_W-1:0]         op;
    logic                    valid_out;
    logic [RESULT_W-1:0]     sum_out;
    logic [RESULT_W-1:0]     carry_out;

    logic [COEFF_WORD_W-1:0] rom_ref [ROM_DEPTH];
    logic [RESULT_W-1:0]     expected_q [$];
    string                   name_q [$];
    string                   current_test;
    logic                    en_d1;
    logic                    en_d2;
    logic [RESULT_W-1:0]     mod_sum;
    logic [RESULT_W-1:0]     expected;
    string                   name;
    int                      cycle_count;
    int                      result_checks;
    int                      value_errors;
    int                      valid_errors;
    int                      other_errors;
    int                      assert_errors;

    seed_eval_top UUT (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .is_sqrt   (is_sqrt),
        .op        (op),
        .valid_out (valid_out),
        .sum_out   (sum_out),
        .carry_out (carry_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Reference model and operand helpers
    ////////////////////////////////////////

    // V modulo 2^RESULT_W from the seed formula
    function automatic logic [RESULT_W-1:0] expected_result(
        input logic            mode,
        input logic [OP_W-1:0] word
    );
        logic [IDX_W-1:0]        index;
        logic signed [X_W-1:0]   x_slice;
        logic [SQ_IN_W-1:0]      sq_slice;
        logic [COEFF_WORD_W-1:0] coeff;
        logic [3:0]              codes;
        longint                  sq;
        longint                  v;
        index    = word[OP_W-1 -: IDX_W];
        x_slice  = word[OP_W-IDX_W-1 -: X_W];
        sq_slice = word[OP_W-IDX_W-1 -: SQ_IN_W];
        coeff    = rom_ref[{mode, index}];
        codes    = EXP_SHIFT_TABLE[{mode, coeff[EXP_LSB +: EXP_W]}];
        sq       = (longint'(sq_slice) * longint'(sq_slice)) >> 16;
        v = longint'(coeff[C0_W-1:0]) <<< (HEADROOM + (index == '0));
        v = v + ((longint'(coeff[C1_LSB +: C1_W]) * longint'(x_slice)) <<< (HEADROOM - codes[1:0]));
        v = v + ((longint'(coeff[C2_LSB +: C2_W]) * sq) <<< (HEADROOM - codes[3:2]));
        return v[RESULT_W-1:0];
    endfunction

    function automatic logic [OP_W-1:0] random_word();
        return OP_W'({$urandom(), $urandom()});
    endfunction

    function automatic logic [OP_W-1:0] set_index(input logic [OP_W-1:0] word,
                                                  input logic [IDX_W-1:0] index);
        operand_u w;
        w = word;
        w.linear_view.index = index;
        return w;
    endfunction

    function automatic logic [OP_W-1:0] set_linear(input logic [OP_W-1:0] word,
                                                   input logic [X_W-1:0] x);
        operand_u w;
        w = word;
        w.linear_view.x = x;
        return w;
    endfunction

    function automatic logic [OP_W-1:0] set_square(input logic [OP_W-1:0] word,
                                                   input logic [SQ_IN_W-1:0] sq);
        operand_u w;
        w = word;
        w.square_view.sq = sq;
        return w;
    endfunction

    ////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////

    task automatic send_item(input logic mode, input logic [OP_W-1:0] word);
        @(posedge clk);
        enable  <= 1'b1;
        is_sqrt <= mode;
        op      <= word;
        expected_q.push_back(expected_result(mode, word));
        name_q.push_back(current_test);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            enable  <= 1'b0;
            is_sqrt <= 1'($urandom_range(1));
            op      <= random_word();
        end
    endtask

    task automatic check_result(input string test, input logic [RESULT_W-1:0] exp_value,
                                input logic [RESULT_W-1:0] act_value);
        result_checks++;
        if (act_value !== exp_value)
        begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", test, exp_value, act_value);
        end
    endtask

    task automatic check_valid(input string test, input logic exp_valid, input logic act_valid);
        if (act_valid !== exp_valid)
        begin
            valid_errors++;
            $display("FAILED %s valid_out: expected %b, actual %b", test, exp_valid, act_valid);
        end
    endtask

    // Outputs settle after the rising edge, so they are compared at the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_valid(current_test, en_d2, valid_out);
            if (valid_out === 1'b1)
            begin
                mod_sum = sum_out + carry_out;
                if (expected_q.size() == 0)
                begin
                    other_errors++;
                    $display("A result appeared at %0t with no enable waiting for it", $time);
                end
                else
                begin
                    expected = expected_q.pop_front();
                    name     = name_q.pop_front();
                    check_result(name, expected, mod_sum);
                end
            end
            en_d2 = en_d1;
            en_d1 = enable;
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        logic [IDX_W-1:0] idx;
        logic [OP_W-1:0]  base;
        int               gap;
        int               waited;
        void'($urandom(32'he4c382d2));
        $readmemh(ROM_FILE, rom_ref);
        rst           = 1'b1;
        enable        = 1'b0;
        is_sqrt       = 1'b0;
        op            = '0;
        en_d1         = 1'b0;
        en_d2         = 1'b0;
        result_checks = 0;
        value_errors  = 0;
        valid_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        current_test  = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // No enable, so no result may appear
        current_test = "reset_idle";
        idle_cycles(10);

        current_test = "reciprocal";
        for (int i = 0; i < RANDOM_COUNT; i++)
            send_item(1'b0, random_word());
        idle_cycles(3);

        current_test = "square_root";
        for (int i = 0; i < RANDOM_COUNT; i++)
            send_item(1'b1, random_word());
        idle_cycles(3);

        current_test = "zero_index";
        for (int i = 0; i < 64; i++)
        begin
            idx = (i % 2 == 0) ? '0 : IDX_W'($urandom_range(15, 1));
            send_item(1'($urandom_range(1)), set_index(random_word(), idx));
        end
        idle_cycles(3);

        // Most negative and most positive X, full square slice, zero and minus one
        current_test = "extremes";
        for (int m = 0; m < 2; m++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                idx  = (k == 0) ? '0 : IDX_W'($urandom_range(15, 1));
                base = set_index(random_word(), idx);
                send_item(m[0], set_linear(base, {1'b1, {(X_W-1){1'b0}}}));
                send_item(m[0], set_linear(base, {1'b0, {(X_W-1){1'b1}}}));
                send_item(m[0], set_square(base, '1));
                send_item(m[0], set_linear(base, '0));
                send_item(m[0], set_linear(base, '1));
            end
        end
        idle_cycles(3);

        current_test = "throughput";
        for (int i = 0; i < 200; i++)
        begin
            send_item(1'($urandom_range(1)), random_word());
            gap = $urandom_range(3);
            if (gap > 0)
                idle_cycles(gap);
        end

        current_test = "drain";
        waited = 0;
        idle_cycles(1);
        while (expected_q.size() != 0 && waited < 10)
        begin
            idle_cycles(1);
            waited++;
        end
        idle_cycles(4);
        if (expected_q.size() != 0)
        begin
            other_errors++;
            $display("%0d results never appeared", expected_q.size());
        end

        assert_errors = UUT.u_assertions.failures;
        $write("Summary: %0d results checked, %0d value errors, %0d valid errors, ",
               result_checks, value_errors, valid_errors);
        $display("%0d other errors, %0d assertion failures", other_errors, assert_errors);
        if (value_errors + valid_errors + other_errors + assert_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/seed_eval_assertions.sv
`timescale 1ns/10ps

module seed_eval_assertions
    import seed_params_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                enable,
    input logic                valid_out,
    input logic [RESULT_W-1:0] sum_out,
    input logic [RESULT_W-1:0] carry_out
);

    int failures = 0;

    // Both valid stages clear on reset
    reset_clears_valid: assert property (@(posedge clk) rst |=> !valid_out)
        else
        begin
            failures++;
            $error("valid_out is high in the cycle after reset");
        end

    // Fixed latency of two cycles
    valid_follows_enable: assert property (@(posedge clk) disable iff (rst)
        valid_out == $past(enable, 2))
        else
        begin
            failures++;
            $error("valid_out does not match enable from two cycles earlier");
        end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> !$isunknown({sum_out, carry_out}))
        else
        begin
            failures++;
            $error("sum_out or carry_out holds unknown bits while valid_out is high");
        end

endmodule

bind seed_eval_top seed_eval_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .valid_out (valid_out),
    .sum_out   (sum_out),
    .carry_out (carry_out)
);

//--- rtl/seed_eval_top.sv
`timescale 1ns/10ps

module seed_eval_top
    import seed_params_pkg::*;
    import seed_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  logic                is_sqrt,
    input  logic [OP_W-1:0]     op,
    output logic                valid_out,
    output logic [RESULT_W-1:0] sum_out,
    output logic [RESULT_W-1:0] carry_out
);

    seed_pipe_if pipe_if ();

    // Table lookup, squaring and recoding
    operand_stage u_operand_stage (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .is_sqrt (is_sqrt),
        .op      (operand_u'(op)),
        .pipe    (pipe_if.producer)
    );

    // Reduction to sum and carry words
    pp_reduce #(.RESULT_W(RESULT_W)) u_pp_reduce (
        .clk       (clk),
        .rst       (rst),
        .pipe      (pipe_if.consumer),
        .valid_out (valid_out),
        .sum_out   (sum_out),
        .carry_out (carry_out)
    );

endmodule

//--- rtl/pp_reduce.sv
`timescale 1ns/10ps

module pp_reduce
    import seed_params_pkg::*;
#(
    parameter int RESULT_W = seed_params_pkg::RESULT_W
)
(
    input  logic                clk,
    input  logic                rst,
    seed_pipe_if.consumer       pipe,
    output logic                valid_out,
    output logic [RESULT_W-1:0] sum_out,
    output logic [RESULT_W-1:0] carry_out
);

    localparam int N_ROWS   = X_DIGITS + SQ_DIGITS + 2;
    localparam int N_NODES  = 3 * N_ROWS - 4;
    localparam int C0_ROW   = X_DIGITS + SQ_DIGITS;
    localparam int CORR_ROW = C0_ROW + 1;

    logic [2:0]           x_align;
    logic [2:0]           sq_align;
    logic [X_DIGITS-1:0]  x_prev;
    logic [SQ_DIGITS-1:0] sq_prev;
    logic [RESULT_W-1:0]  node [N_NODES];

    // One Booth row, sign extended by inversion, placed at pos then aligned
    // The +1 of the digit below rides in the two free bits under pos
    function automatic logic [RESULT_W-1:0] booth_row(
        input logic [RESULT_W-1:0] coeff,
        input logic                sign,
        input logic                two,
        input logic                zero,
        input logic                prev_sign,
        input int                  pos,
        input logic [2:0]          align
    );
        logic [RESULT_W-1:0] mag;
        logic [RESULT_W-1:0] row;
        mag = zero ? '0 : (two ? (coeff << 1) : coeff);
        row = (sign ? ~mag : mag) << pos;
        if (pos >= 2)
            row = row | (RESULT_W'(prev_sign) << (pos - 2));
        return row << align;
    endfunction

    // Left alignment left over after the right shift code
    assign x_align  = 3'(HEADROOM) - {1'b0, pipe.s1};
    assign sq_align = 3'(HEADROOM) - {1'b0, pipe.s2};

    assign x_prev  = {pipe.x_sign[X_DIGITS-2:0], 1'b0};
    assign sq_prev = {pipe.sq_sign[SQ_DIGITS-2:0], 1'b0};

    ////////////////////////////////////////
    // Partial product rows
    ////////////////////////////////////////

    for (genvar i = 0; i < X_DIGITS; i++)
    begin : g_x_rows
        assign node[i] = booth_row(RESULT_W'(pipe.c1), pipe.x_sign[i], pipe.x_two[i],
                                   pipe.x_zero[i], x_prev[i], 2 * i, x_align);
    end

    for (genvar j = 0; j < SQ_DIGITS; j++)
    begin : g_sq_rows
        assign node[X_DIGITS+j] = booth_row(RESULT_W'(pipe.c2), pipe.sq_sign[j],
                                            pipe.sq_two[j], pipe.sq_zero[j], sq_prev[j],
                                            2 * j, sq_align);
    end

    // Constant term, doubled for a zero index
    assign node[C0_ROW] = (RESULT_W'(pipe.c0) << HEADROOM) << pipe.zero_index;

    // Negation carry of the top linear digit
    // The top square digit sees zero extension and is never negative
    assign node[CORR_ROW] =
        (RESULT_W'(pipe.x_sign[X_DIGITS-1]) << (2 * X_DIGITS - 2)) << x_align;

    ////////////////////////////////////////
    // Carry-save tree
    ////////////////////////////////////////

    // Each compressor takes the three oldest rows and appends two new ones
    // The last two nodes are the redundant result
    for (genvar m = 0; m < N_ROWS - 2; m++)
    begin : g_csa
        logic [RESULT_W-1:0] a;
        logic [RESULT_W-1:0] b;
        logic [RESULT_W-1:0] c;

        assign a = node[3*m];
        assign b = node[3*m+1];
        assign c = node[3*m+2];

        assign node[N_ROWS+2*m]   = a ^ b ^ c;
        assign node[N_ROWS+2*m+1] = ((a & b) | (a & c) | (b & c)) << 1;
    end

    always_ff @(posedge clk)
    begin
        sum_out   <= node[N_NODES-2];
        carry_out <= node[N_NODES-1];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_out <= 1'b0;
        else
            valid_out <= pipe.valid;
    end

endmodule

//--- rtl/operand_stage.sv
`timescale 1ns/10ps

module operand_stage
    import seed_params_pkg::*;
    import seed_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          enable,
    input  logic          is_sqrt,
    input  operand_u      op,
    seed_pipe_if.producer pipe
);

    logic [IDX_W-1:0]      index_d;
    logic signed [X_W-1:0] x_d;
    logic [SQ_IN_W-1:0]    sq_in;
    logic [SQ_IN_W-1:0]    sq_val;
    logic [C0_W-1:0]       c0_d;
    logic [C1_W-1:0]       c1_d;
    logic [C2_W-1:0]       c2_d;
    logic [1:0]            s1_d;
    logic [1:0]            s2_d;
    logic                  zero_index_d;
    logic [X_DIGITS-1:0]   x_sign_d;
    logic [X_DIGITS-1:0]   x_two_d;
    logic [X_DIGITS-1:0]   x_zero_d;
    logic [SQ_DIGITS-1:0]  sq_sign_d;
    logic [SQ_DIGITS-1:0]  sq_two_d;
    logic [SQ_DIGITS-1:0]  sq_zero_d;

    // Same word read as linear slice and as square slice
    assign index_d      = op.linear_view.index;
    assign x_d          = op.linear_view.x;
    assign sq_in        = op.square_view.sq;
    assign zero_index_d = (index_d == '0);

    coeff_table u_coeff_table (
        .is_sqrt (is_sqrt),
        .index   (index_d),
        .c0      (c0_d),
        .c1      (c1_d),
        .c2      (c2_d),
        .s1      (s1_d),
        .s2      (s2_d)
    );

    square_unit u_square_unit (
        .a  (sq_in),
        .sq (sq_val)
    );

    booth_recoder #(.DIGITS(X_DIGITS), .SIGNED_IN(1'b1)) u_x_recoder (
        .value (x_d),
        .sign  (x_sign_d),
        .two   (x_two_d),
        .zero  (x_zero_d)
    );

    booth_recoder #(.DIGITS(SQ_DIGITS), .SIGNED_IN(1'b0)) u_sq_recoder (
        .value ((2*SQ_DIGITS)'(sq_val)),
        .sign  (sq_sign_d),
        .two   (sq_two_d),
        .zero  (sq_zero_d)
    );

    ////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        pipe.c0         <= c0_d;
        pipe.c1         <= c1_d;
        pipe.c2         <= c2_d;
        pipe.s1         <= s1_d;
        pipe.s2         <= s2_d;
        pipe.zero_index <= zero_index_d;
        pipe.x_sign     <= x_sign_d;
        pipe.x_two      <= x_two_d;
        pipe.x_zero     <= x_zero_d;
        pipe.sq_sign    <= sq_sign_d;
        pipe.sq_two     <= sq_two_d;
        pipe.sq_zero    <= sq_zero_d;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pipe.valid <= 1'b0;
        else
            pipe.valid <= enable;
    end

endmodule

//--- rtl/booth_recoder.sv
`timescale 1ns/10ps

module booth_recoder
    import seed_params_pkg::*;
#(
    parameter int DIGITS    = X_DIGITS,
    parameter bit SIGNED_IN = 1'b1
)
(
    input  logic [2*DIGITS-1:0] value,
    output logic [DIGITS-1:0]   sign,
    output logic [DIGITS-1:0]   two,
    output logic [DIGITS-1:0]   zero
);

    // Scan vector with the implicit zero below bit 0
    logic [2*DIGITS:0] ext;

    // Unsigned values sit in the lower 2*DIGITS-2 bits
    // and the top digit sees zero extension
    assign ext = SIGNED_IN ? {value, 1'b0}
                           : {2'b00, value[2*DIGITS-3:0], 1'b0};

    for (genvar d = 0; d < DIGITS; d++)
    begin : g_digit
        logic [2:0] grp;

        assign grp = ext[2*d +: 3];

        // 111 is a zero digit and is kept positive
        assign sign[d] = grp[2] & ~(grp[1] & grp[0]);
        // 011 and 100
        assign two[d]  = (grp[2] ^ grp[1]) & ~(grp[1] ^ grp[0]);
        // 000 and 111
        assign zero[d] = ~(grp[2] ^ grp[1]) & ~(grp[1] ^ grp[0]);
    end

endmodule

//--- rtl/square_unit.sv
`timescale 1ns/10ps

module square_unit
    import seed_params_pkg::*;
(
    input  logic [SQ_IN_W-1:0] a,
    output logic [SQ_IN_W-1:0] sq
);

    localparam int FULL_W = 2 * SQ_IN_W;

    logic [FULL_W-1:0] rows [SQ_IN_W];
    logic [FULL_W-1:0] full;

    // Row i has a[i] on the diagonal at 2i
    // Cross terms a[i]&a[j] for j>i appear once, one place up, for the pair
    always_comb
    begin
        for (int i = 0; i < SQ_IN_W; i++)
        begin
            rows[i] = '0;
            rows[i][2*i] = a[i];
            for (int j = i + 1; j < SQ_IN_W; j++)
            begin
                rows[i][i+j+1] = a[i] & a[j];
            end
        end
    end

    always_comb
    begin
        full = '0;
        for (int i = 0; i < SQ_IN_W; i++)
        begin
            full = full + rows[i];
        end
    end

    // Floor of the square over 2^16
    assign sq = full[FULL_W-1 -: SQ_IN_W];

endmodule

//--- rtl/coeff_table.sv
`timescale 1ns/10ps

module coeff_table
    import seed_params_pkg::*;
(
    input  logic             is_sqrt,
    input  logic [IDX_W-1:0] index,
    output logic [C0_W-1:0]  c0,
    output logic [C1_W-1:0]  c1,
    output logic [C2_W-1:0]  c2,
    output logic [1:0]       s1,
    output logic [1:0]       s2
);

    logic [COEFF_WORD_W-1:0] rom [ROM_DEPTH];
    logic [COEFF_WORD_W-1:0] word;
    logic [EXP_W-1:0]        exponent;
    logic [3:0]              codes;

    initial
    begin
        $readmemh(ROM_FILE, rom);
    end

    // Lower half for reciprocal, upper half for square root
    assign word = rom[{is_sqrt, index}];

    assign c0       = word[C0_W-1:0];
    assign c1       = word[C1_LSB +: C1_W];
    assign c2       = word[C2_LSB +: C2_W];
    assign exponent = word[EXP_LSB +: EXP_W];

    // Exponent and mode pick the right shift of each product
    assign codes = EXP_SHIFT_TABLE[{is_sqrt, exponent}];
    assign s2    = codes[3:2];
    assign s1    = codes[1:0];

endmodule

//--- rtl/seed_pipe_if.sv
`timescale 1ns/10ps

interface seed_pipe_if
    import seed_params_pkg::*;
();
    logic [C0_W-1:0]      c0;
    logic [C1_W-1:0]      c1;
    logic [C2_W-1:0]      c2;
    logic                 zero_index;
    logic [1:0]           s1;
    logic [1:0]           s2;
    logic [X_DIGITS-1:0]  x_sign;
    logic [X_DIGITS-1:0]  x_two;
    logic [X_DIGITS-1:0]  x_zero;
    logic [SQ_DIGITS-1:0] sq_sign;
    logic [SQ_DIGITS-1:0] sq_two;
    logic [SQ_DIGITS-1:0] sq_zero;
    logic                 valid;

    modport producer (output c0, c1, c2, zero_index, s1, s2, x_sign, x_two, x_zero,
                      sq_sign, sq_two, sq_zero, valid);
    modport consumer (input c0, c1, c2, zero_index, s1, s2, x_sign, x_two, x_zero,
                      sq_sign, sq_two, sq_zero, valid);

endinterface

//--- rtl/seed_types_pkg.sv
package seed_types_pkg;

    import seed_params_pkg::*;

    // Index on top, then the signed linear slice
    typedef struct packed {
        logic [IDX_W-1:0]        index;
        logic signed [X_W-1:0]   x;
        logic [X_REM_W-1:0]      rest;
    } linear_view_t;

    // Index on top, then the unsigned square slice
    // The square slice is the upper part of the linear slice
    typedef struct packed {
        logic [IDX_W-1:0]    index;
        logic [SQ_IN_W-1:0]  sq;
        logic [SQ_REM_W-1:0] rest;
    } square_view_t;

    typedef union packed {
        linear_view_t linear_view;
        square_view_t square_view;
    } operand_u;

endpackage

//--- rtl/seed_params_pkg.sv
package seed_params_pkg;

    // Operand word layout
    localparam int OP_W     = 40;
    localparam int IDX_W    = 4;
    localparam int X_W      = 24;
    localparam int SQ_IN_W  = 16;
    localparam int X_REM_W  = OP_W - IDX_W - X_W;
    localparam int SQ_REM_W = OP_W - IDX_W - SQ_IN_W;

    // Coefficient word, from the top: exponent, c2, c1, c0
    localparam int C0_W         = 30;
    localparam int C1_W         = 20;
    localparam int C2_W         = 12;
    localparam int EXP_W        = 2;
    localparam int COEFF_WORD_W = 64;
    localparam int C1_LSB       = C0_W;
    localparam int C2_LSB       = C0_W + C1_W;
    localparam int EXP_LSB      = C0_W + C1_W + C2_W;
    localparam int ROM_DEPTH    = 2 ** (IDX_W + 1);

    // Datapath
    localparam int RESULT_W  = 48;
    localparam int X_DIGITS  = 12;
    localparam int SQ_DIGITS = 9;
    localparam int HEADROOM  = 3;

    // Right shift codes {s2, s1} by {is_sqrt, exponent}
    localparam logic [3:0] EXP_SHIFT_TABLE [8] = '{
        4'b0000, 4'b0100, 4'b0101, 4'b1001,
        4'b0101, 4'b1001, 4'b1101, 4'b1110
    };

    localparam string ROM_FILE = "rtl/coeff_rom.mem";

endpackage
